// ==== hw/audio_decim_pkg.sv ====
// shared defaults; CALC_W - SND_W must equal N_STAGES*log2(RATE*COMB_M), RATE a power of two.
package audio_decim_pkg;

    // --------------------
    // sample format
    // --------------------
    localparam int SND_W = 16;  // signed two's complement in and out.

    // internal accumulator width.
    // growth is N_STAGES*log2(RATE*COMB_M) bits, so 16 + 2*1 = 18
    // gives unity dc gain after truncation.
    localparam int CALC_W = 18;

    // --------------------
    // filter shape
    // --------------------
    localparam int N_STAGES = 2;  // integrators and combs, each.
    localparam int COMB_M   = 1;  // comb differential delay, output samples.
    localparam int RATE     = 2;  // decimation factor.

    // strobe counter width for the enable generator.
    // keeps at least one bit when RATE is 1.
    localparam int CNT_W = (RATE > 1) ? $clog2(RATE) : 1;

    // bit growth of the whole cic at the default shape.
    localparam int GROWTH = N_STAGES * $clog2(RATE * COMB_M);

endpackage

// ==== hw/decim_cen_gen.sv ====
// output-rate enable; cen_out rides on every RATE-th sample_in, CNT_W must hold RATE-1.
module decim_cen_gen #(
    parameter int RATE  = audio_decim_pkg::RATE,
    parameter int CNT_W = audio_decim_pkg::CNT_W
) (
    input  logic clk,
    input  logic rst,
    input  logic sample_in,  // one-cycle input strobe.
    output logic cen_out     // output-rate enable, same cycle as strobe.
);

    // --------------------
    // strobe counter
    // --------------------
    localparam logic [CNT_W-1:0] LAST = CNT_W'(RATE - 1);  // last slot of a group.

    logic [CNT_W-1:0] cnt;  // strobes seen in the current group.
    logic             last_slot;

    assign last_slot = (cnt == LAST);

    // modulo-RATE count, advances only on strobes.
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (sample_in) begin
            if (last_slot) begin
                cnt <= '0;  // group complete, wrap.
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // --------------------
    // enable
    // --------------------
    // combinational on purpose so the combs see the same strobe
    // that the integrators see. the rate-change register then picks up
    // the integrator value before this strobe's update.
    assign cen_out = sample_in && last_slot;

    // --------------------
    // checks
    // --------------------
    // enable never without a strobe.
    a_cen_needs_strobe : assert property (
        @(posedge clk) disable iff (rst)
        cen_out |-> sample_in
    ) else $error("decim_cen_gen: cen_out without sample_in");

    // RATE strobes after a wrap, the enable must come round again.
    a_cen_period : assert property (
        @(posedge clk) disable iff (rst)
        (cen_out ##1 (sample_in [->RATE])) |-> cen_out
    ) else $error("decim_cen_gen: enable missed its RATE-th strobe");

endmodule

// ==== hw/cic_comb_stage.sv ====
// one cic comb section; wrap-around arithmetic, M is the delay in enabled cycles.
module cic_comb_stage #(
    parameter int W = audio_decim_pkg::CALC_W,
    parameter int M = audio_decim_pkg::COMB_M
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,      // output-rate enable.
    input  logic signed [W-1:0] snd_in,
    output logic signed [W-1:0] snd_out
);

    // --------------------
    // delay line
    // --------------------
    logic signed [W-1:0] dly [0:M-1];  // dly[0] newest, dly[M-1] oldest.

    // y[n] = x[n] - x[n-M], registered.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < M; i++) begin
                dly[i] <= '0;
            end
            snd_out <= '0;
        end else if (cen) begin
            dly[0] <= snd_in;  // shift in the current sample.
            for (int i = 1; i < M; i++) begin
                dly[i] <= dly[i-1];
            end
            snd_out <= snd_in - dly[M-1];  // overflow wraps, cancels with integrators.
        end
    end

endmodule

// ==== hw/cic_decim.sv ====
// one cic decimator channel; output is plain truncation, no rounding or saturation.
module cic_decim #(
    parameter int SND_W    = audio_decim_pkg::SND_W,
    parameter int CALC_W   = audio_decim_pkg::CALC_W,
    parameter int N_STAGES = audio_decim_pkg::N_STAGES,
    parameter int COMB_M   = audio_decim_pkg::COMB_M,
    parameter int RATE     = audio_decim_pkg::RATE
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cen_in,   // input-rate enable.
    input  logic                    cen_out,  // output-rate enable.
    input  logic signed [SND_W-1:0] snd_in,
    output logic signed [SND_W-1:0] snd_out
);

    localparam int WDIFF = CALC_W - SND_W;  // guard bits for growth.

    // --------------------
    // integrator chain
    // --------------------
    logic signed [CALC_W-1:0] snd_ext;                 // sign-extended input.
    logic signed [CALC_W-1:0] integ [1:N_STAGES];      // accumulators.

    assign snd_ext = {{WDIFF{snd_in[SND_W-1]}}, snd_in};

    // each stage adds the previous stage's registered value.
    // wrap-around is fine here, the combs undo it.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 1; k <= N_STAGES; k++) begin
                integ[k] <= '0;
            end
        end else if (cen_in) begin
            integ[1] <= integ[1] + snd_ext;  // first stage takes the input.
            for (int k = 2; k <= N_STAGES; k++) begin
                integ[k] <= integ[k] + integ[k-1];
            end
        end
    end

    // --------------------
    // rate change
    // --------------------
    logic signed [CALC_W-1:0] rc_q;  // decimated integrator output.

    // takes the last integrator as it stands before this strobe's update.
    always_ff @(posedge clk) begin
        if (rst) begin
            rc_q <= '0;
        end else if (cen_out) begin
            rc_q <= integ[N_STAGES];
        end
    end

    // --------------------
    // comb chain
    // --------------------
    logic signed [CALC_W-1:0] comb_data [0:N_STAGES];  // [0] in, [N_STAGES] out.

    assign comb_data[0] = rc_q;

    for (genvar k = 0; k < N_STAGES; k++) begin : g_comb
        cic_comb_stage #(
            .W (CALC_W),
            .M (COMB_M)
        ) cic_comb_stage_inst (
            .clk     (clk),
            .rst     (rst),
            .cen     (cen_out),
            .snd_in  (comb_data[k]),
            .snd_out (comb_data[k+1])
        );
    end

    // --------------------
    // output
    // --------------------
    // top SND_W bits; the dropped bits are exactly the dc growth.
    always_ff @(posedge clk) begin
        if (rst) begin
            snd_out <= '0;
        end else if (cen_out) begin
            snd_out <= comb_data[N_STAGES][CALC_W-1 -: SND_W];
        end
    end

    // --------------------
    // checks
    // --------------------
    // output-rate enable must coincide with an input strobe.
    a_cen_out_in : assert property (
        @(posedge clk) disable iff (rst)
        cen_out |-> cen_in
    ) else $error("cic_decim: cen_out without cen_in");

    // RATE is only carried for the growth rule; reject a zero rate early.
    initial begin
        assert (RATE >= 1)
        else $error("cic_decim: RATE must be at least 1");
    end

endmodule

// ==== hw/stereo_decim_top.sv ====
// stereo cic decimator; strobes need an idle cycle between them, no back-pressure.
module stereo_decim_top #(
    parameter int SND_W    = audio_decim_pkg::SND_W,
    parameter int CALC_W   = audio_decim_pkg::CALC_W,
    parameter int N_STAGES = audio_decim_pkg::N_STAGES,
    parameter int COMB_M   = audio_decim_pkg::COMB_M,
    parameter int RATE     = audio_decim_pkg::RATE
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    sample_in,   // input strobe.
    input  logic signed [SND_W-1:0] snd_in_l,
    input  logic signed [SND_W-1:0] snd_in_r,
    output logic                    sample_out,  // new outputs this cycle.
    output logic signed [SND_W-1:0] snd_out_l,
    output logic signed [SND_W-1:0] snd_out_r
);

    localparam int CNT_W  = (RATE > 1) ? $clog2(RATE) : 1;  // follows RATE.
    localparam int GROWTH = N_STAGES * $clog2(RATE * COMB_M);

    // --------------------
    // parameter check
    // --------------------
    // unity dc gain needs the guard bits to match the growth exactly.
    if (CALC_W - SND_W != GROWTH) begin : g_bad_width
        $error("stereo_decim_top: CALC_W - SND_W must equal cic bit growth");
    end

    // --------------------
    // enable generator
    // --------------------
    logic cen_out;  // output-rate enable, shared by both channels.

    decim_cen_gen #(
        .RATE  (RATE),
        .CNT_W (CNT_W)
    ) decim_cen_gen_inst (
        .clk       (clk),
        .rst       (rst),
        .sample_in (sample_in),
        .cen_out   (cen_out)
    );

    // --------------------
    // channels
    // --------------------
    cic_decim #(
        .SND_W    (SND_W),
        .CALC_W   (CALC_W),
        .N_STAGES (N_STAGES),
        .COMB_M   (COMB_M),
        .RATE     (RATE)
    ) cic_decim_l_inst (
        .clk     (clk),
        .rst     (rst),
        .cen_in  (sample_in),  // integrators at input rate.
        .cen_out (cen_out),
        .snd_in  (snd_in_l),
        .snd_out (snd_out_l)
    );

    cic_decim #(
        .SND_W    (SND_W),
        .CALC_W   (CALC_W),
        .N_STAGES (N_STAGES),
        .COMB_M   (COMB_M),
        .RATE     (RATE)
    ) cic_decim_r_inst (
        .clk     (clk),
        .rst     (rst),
        .cen_in  (sample_in),
        .cen_out (cen_out),
        .snd_in  (snd_in_r),
        .snd_out (snd_out_r)
    );

    // outputs land one clock after cen_out, so does the strobe.
    always_ff @(posedge clk) begin
        if (rst) begin
            sample_out <= 1'b0;
        end else begin
            sample_out <= cen_out;
        end
    end

    // --------------------
    // checks
    // --------------------
    // strobes at least one idle cycle apart.
    a_strobe_gap : assert property (
        @(posedge clk) disable iff (rst)
        sample_in |=> !sample_in
    ) else $error("stereo_decim_top: sample_in strobes too close");

endmodule

// ==== test/tb_clk_gen.sv ====
// free-running testbench clock, starts low; PERIOD must be even.
module tb_clk_gen #(
    parameter int PERIOD = 10
) (
    output logic clk
);

    // first rising edge at PERIOD/2.
    initial begin
        clk = 1'b0;
    end

    always begin
        #(PERIOD / 2);
        clk = ~clk;  // half period per toggle.
    end

endmodule

// ==== test/stereo_decim_tb.sv ====
// table-driven check of stereo_decim_top; settle counts assume the default filter shape.
module stereo_decim_tb;

    localparam int SW      = audio_decim_pkg::SND_W;
    localparam int CW      = audio_decim_pkg::CALC_W;
    localparam int NS      = audio_decim_pkg::N_STAGES;
    localparam int CM      = audio_decim_pkg::COMB_M;
    localparam int RATE    = audio_decim_pkg::RATE;
    localparam int TIMEOUT = 50;  // clocks to wait for sample_out.
    localparam int NROWS   = 10;
    // pipeline of NS+1 output samples, plus the filter span and strobe phase.
    localparam int SETTLE  = 2 * NS + 2;
    localparam int K_DC    = 0;  // constant amp.
    localparam int K_ALT   = 1;  // +amp, -amp, ...
    localparam int K_RAND  = 2;  // full-range random.

    logic                 clk;
    logic                 rst;
    logic                 sample_in;
    logic                 sample_out;
    logic signed [SW-1:0] snd_in_l;
    logic signed [SW-1:0] snd_in_r;
    logic signed [SW-1:0] snd_out_l;
    logic signed [SW-1:0] snd_out_r;

    int          err_cnt    = 0;
    int          strobe_cnt = 0;  // sample_in strobes since reset.
    int          pulse_cnt  = 0;  // sample_out pulses since reset.
    bit          timed_out  = 1'b0;
    int unsigned seed_ret;

    // --------------------
    // stimulus table
    // --------------------
    string row_name [NROWS];
    int    row_kl   [NROWS];
    int    row_al   [NROWS];
    int    row_kr   [NROWS];
    int    row_ar   [NROWS];
    int    row_n    [NROWS];

    // --------------------
    // reference model state, [channel]
    // --------------------
    logic signed [CW-1:0] mi [0:1][1:NS];          // integrators.
    logic signed [CW-1:0] mrc [0:1];               // decimated value.
    logic signed [CW-1:0] mc [0:1][1:NS];          // comb outputs.
    logic signed [CW-1:0] md [0:1][1:NS][0:CM-1];  // comb delay lines.

    tb_clk_gen #(
        .PERIOD (10)
    ) tb_clk_gen_inst (
        .clk (clk)
    );

    stereo_decim_top #(
        .SND_W    (SW),
        .CALC_W   (CW),
        .N_STAGES (NS),
        .COMB_M   (CM),
        .RATE     (RATE)
    ) stereo_decim_top_inst (
        .clk        (clk),
        .rst        (rst),
        .sample_in  (sample_in),
        .snd_in_l   (snd_in_l),
        .snd_in_r   (snd_in_r),
        .sample_out (sample_out),
        .snd_out_l  (snd_out_l),
        .snd_out_r  (snd_out_r)
    );

    // pulses counted mid-cycle, where sample_out is stable.
    always @(negedge clk) begin
        if (sample_out) begin
            pulse_cnt++;
        end
    end

    task automatic check_val(input string what, input int exp, input int act);
        if (exp !== act) begin
            $display("Error: %s expected %0d actual %0d", what, exp, act);
            err_cnt++;
        end
    endtask

    task automatic set_row(input int i, input string name, input int kl, input int al,
                           input int kr, input int ar, input int n);
        row_name[i] = name;
        row_kl[i]   = kl;
        row_al[i]   = al;
        row_kr[i]   = kr;
        row_ar[i]   = ar;
        row_n[i]    = n;
    endtask

    task automatic fill_table();
        set_row(0, "dc_zero", K_DC, 0, K_DC, 0, 16);
        set_row(1, "dc_pos_full", K_DC, 32767, K_DC, 32767, 20);
        set_row(2, "dc_neg_full", K_DC, -32768, K_DC, -32768, 21);  // odd, shifts phase.
        set_row(3, "dc_mixed", K_DC, 1234, K_DC, -4321, 20);
        set_row(4, "alt_left", K_ALT, 20000, K_DC, 500, 23);
        set_row(5, "alt_both", K_ALT, 32767, K_ALT, 1000, 20);
        set_row(6, "rand_both", K_RAND, 0, K_RAND, 0, 60);
        set_row(7, "rand_left_dc_right", K_RAND, 0, K_DC, -1, 41);
        set_row(8, "alt_right_rand_left", K_RAND, 0, K_ALT, 12345, 40);
        set_row(9, "dc_back_to_zero", K_DC, 0, K_DC, 0, 18);
    endtask

    // --------------------
    // reference model
    // --------------------
    task automatic init_model();
        for (int ch = 0; ch < 2; ch++) begin
            mrc[ch] = '0;
            for (int k = 1; k <= NS; k++) begin
                mi[ch][k] = '0;
                mc[ch][k] = '0;
                for (int j = 0; j < CM; j++) begin
                    md[ch][k][j] = '0;
                end
            end
        end
    endtask

    // one input sample; on an output-rate strobe y is the value that
    // shows up with the following sample_out.
    task automatic model_step(input int ch, input logic signed [SW-1:0] x, input bit cen,
                              output logic signed [SW-1:0] y);
        logic signed [CW-1:0] c_in;
        y = '0;
        if (cen) begin
            y = SW'(mc[ch][NS] >>> (CW - SW));  // drop the growth bits.
            // last stage first, so each stage sees the old value upstream.
            for (int k = NS; k >= 1; k--) begin
                c_in = (k == 1) ? mrc[ch] : mc[ch][k-1];
                mc[ch][k] = c_in - md[ch][k][CM-1];
                for (int j = CM - 1; j >= 1; j--) begin
                    md[ch][k][j] = md[ch][k][j-1];
                end
                md[ch][k][0] = c_in;
            end
            mrc[ch] = mi[ch][NS];  // value before this sample's update.
        end
        for (int k = NS; k >= 2; k--) begin
            mi[ch][k] = mi[ch][k] + mi[ch][k-1];
        end
        mi[ch][1] = mi[ch][1] + CW'(x);  // sign-extended add, wraps.
    endtask

    function automatic logic signed [SW-1:0] pattern(input int kind, input int amp,
                                                     input int idx);
        case (kind)
            K_DC:    return SW'(amp);
            K_ALT:   return (idx % 2 == 0) ? SW'(amp) : SW'(-amp);
            default: return SW'($urandom);
        endcase
    endfunction

    // settled output of a constant or alternating row.
    function automatic int settle_target(input int kind, input int amp);
        return (kind == K_DC) ? amp : 0;  // alt has a zero at fs/2.
    endfunction

    task automatic check_idle(input string tname);
        check_val({tname, " sample_out"}, 0, int'(sample_out));
        check_val({tname, " left"}, 0, int'(snd_out_l));
        check_val({tname, " right"}, 0, int'(snd_out_r));
    endtask

    task automatic wait_sample_out(input string tname, output int waited);
        waited = 0;
        while (!sample_out && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!sample_out) begin
            $display("%s: no sample_out came within %0d clocks of an output strobe",
                     tname, TIMEOUT);
            err_cnt++;
            timed_out = 1'b1;
        end
    endtask

    // --------------------
    // one table row
    // --------------------
    task automatic run_row(input int i);
        logic signed [SW-1:0] xl;
        logic signed [SW-1:0] xr;
        logic signed [SW-1:0] el;
        logic signed [SW-1:0] er;
        bit                   cen;
        int                   gap;
        int                   waited;
        int                   out_k;
        int                   strobes_start;
        int                   pulses_start;
        strobes_start = strobe_cnt;
        pulses_start  = pulse_cnt;
        out_k         = 0;
        for (int s = 0; s < row_n[i] && !timed_out; s++) begin
            xl  = pattern(row_kl[i], row_al[i], s);
            xr  = pattern(row_kr[i], row_ar[i], s);
            cen = (strobe_cnt % RATE) == (RATE - 1);  // every RATE-th strobe.
            model_step(0, xl, cen, el);
            model_step(1, xr, cen, er);
            gap = 1 + int'($urandom % 3);  // 1 to 3 idle cycles.
            @(negedge clk);
            sample_in = 1'b1;
            snd_in_l  = xl;
            snd_in_r  = xr;
            strobe_cnt++;
            @(negedge clk);
            sample_in = 1'b0;
            if (cen) begin
                wait_sample_out(row_name[i], waited);
                if (!timed_out) begin
                    out_k++;
                    check_val({row_name[i], " sample_out delay"}, 0, waited);
                    check_val({row_name[i], " left"}, int'(el), int'(snd_out_l));
                    check_val({row_name[i], " right"}, int'(er), int'(snd_out_r));
                    if (row_kl[i] != K_RAND && out_k >= SETTLE) begin
                        check_val({row_name[i], " left settled"},
                                  settle_target(row_kl[i], row_al[i]), int'(snd_out_l));
                    end
                    if (row_kr[i] != K_RAND && out_k >= SETTLE) begin
                        check_val({row_name[i], " right settled"},
                                  settle_target(row_kr[i], row_ar[i]), int'(snd_out_r));
                    end
                end
            end else if (strobe_cnt < RATE) begin
                check_idle({row_name[i], " before first output"});  // still reset values.
            end else begin
                check_val({row_name[i], " stray sample_out"}, 0, int'(sample_out));
            end
            for (int g = 1; g < gap; g++) begin
                @(negedge clk);
                if (strobe_cnt < RATE) begin
                    check_idle({row_name[i], " before first output"});
                end else begin
                    check_val({row_name[i], " stray sample_out"}, 0, int'(sample_out));
                end
            end
        end
        @(posedge clk);  // pulse counter settled by now.
        check_val({row_name[i], " pulse count"},
                  strobe_cnt / RATE - strobes_start / RATE, pulse_cnt - pulses_start);
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial begin
        rst       = 1'b1;
        sample_in = 1'b0;
        snd_in_l  = '0;
        snd_in_r  = '0;
        seed_ret  = $urandom(32'hbf48_1984);  // seeds the generator once.
        fill_table();
        init_model();
        for (int c = 0; c < 10; c++) begin
            @(negedge clk);
            check_idle("reset");
        end
        rst = 1'b0;
        for (int c = 0; c < 3; c++) begin
            @(negedge clk);
            check_idle("post_reset");
        end
        for (int i = 0; i < NROWS; i++) begin
            if (!timed_out) begin
                run_row(i);
            end
        end
        @(negedge clk);
        $display("errors: %0d, strobes in: %0d, strobes out: %0d",
                 err_cnt, strobe_cnt, pulse_cnt);
        if (err_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
hw/audio_decim_pkg.sv
hw/decim_cen_gen.sv
hw/cic_comb_stage.sv
hw/cic_decim.sv
hw/stereo_decim_top.sv
test/tb_clk_gen.sv
test/stereo_decim_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the stereo decimator testbench with Verilator.
# Exits nonzero if the build fails, the simulation fails, or the
# pass message is missing from the simulation output.

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f all.f \
    --top-module stereo_decim_tb \
    --Mdir obj_dir \
    -o stereo_decim_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

sim_out=$(./obj_dir/stereo_decim_sim 2>&1)
status=$?
printf '%s\n' "$sim_out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -q '^Test OK$'; then
    exit 0
else
    echo "pass message not found in simulation output"
    exit 1
fi
